//--- flist.f
hw/cpuPkg.sv
hw/pipeIf.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/cpu.sv
verification/cpu_assert.sv
verification/cpuTb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - files:
      - hw/cpuPkg.sv
      - hw/pipeIf.sv
      - hw/fetchStage.sv
      - hw/decodeStage.sv
      - hw/executeStage.sv
      - hw/memoryStage.sv
      - hw/cpu.sv
  - target: test
    files:
      - verification/cpu_assert.sv
      - verification/cpuTb.sv

//--- verification/cpuTb.sv
module cpuTb
  import cpuPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int progDepth = 1024;
  localparam int stepLimit = 3000;
  // Six tests of a few hundred cycles each, with a wide margin
  localparam int watchdogNs = 20000;
  localparam logic [15:0] nopWord = {OpNop, 12'h000};

  logic                    clk;
  logic                    rstN;
  logic [dataWidth-1:0]    instr;
  logic [dataWidth-1:0]    pc;
  logic                    hlt;
  logic                    regWe;
  logic [regAddrWidth-1:0] regAddr;
  logic [dataWidth-1:0]    regData;

  logic [15:0] prog [progDepth];
  int          progLen;
  int          spacing;
  logic [15:0] model [16];
  logic [15:0] memModel [256];
  logic        zrModel;
  logic        neModel;
  logic        ovModel;
  logic [3:0]  expAddr [$];
  logic [15:0] expData [$];
  logic [31:0] lfsr;
  int          markerCount;
  int          passCount;
  int          failCount;
  int          errorCount;

  cpu UUT (
    .clk     (clk),
    .rstN    (rstN),
    .instr   (instr),
    .pc      (pc),
    .hlt     (hlt),
    .regWe   (regWe),
    .regAddr (regAddr),
    .regData (regData)
  );

  bind cpu cpuAssert portChecks (
    .clk     (clk),
    .rstN    (rstN),
    .hlt     (hlt),
    .regWe   (regWe),
    .regAddr (regAddr)
  );

  always
  begin
    #2;
    clk = ~clk;
  end

  // Instruction memory answers the pc shortly after each edge
  always @(posedge clk)
  begin
    #0.5;
    instr <= prog[pc[9:0]];
  end

  initial
  begin
    #watchdogNs;
    $display("Watchdog expired after %0d ns, the run did not finish", watchdogNs);
    $display("Something failed");
    $finish;
  end

  // **************************************************************************
  // Program building and the reference model
  // **************************************************************************
  function automatic logic [15:0] signExtend8(input logic [7:0] value);
    return {{8{value[7]}}, value};
  endfunction

  function automatic logic [15:0] encodeR(input opcodeT op, input logic [3:0] rd,
                                          input logic [3:0] rs, input logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] encodeImm(input opcodeT op, input logic [3:0] rd,
                                            input logic [7:0] imm8);
    return {op, rd, imm8};
  endfunction

  function automatic logic [15:0] encodeBranch(input condT cond, input logic [8:0] offset);
    return {OpB, cond, offset};
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [15:0] randomBits(input int n);
    logic [15:0] value;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      value = {value[14:0], lfsr[0]};
    end
    return value;
  endfunction

  function automatic logic condHolds(input condT cond);
    logic gt;
    gt = !zrModel && !neModel;
    case (cond)
      CondNe:  return !zrModel;
      CondEq:  return zrModel;
      CondGt:  return gt;
      CondLt:  return neModel;
      CondGe:  return gt || zrModel;
      CondLe:  return neModel || zrModel;
      CondOv:  return ovModel;
      default: return 1'b1;
    endcase
  endfunction

  task automatic startProgram();
    // Unused words halt, tagged with their own address
    for (int i = 0; i < progDepth; i++)
      prog[i] = {OpHlt, 12'(i)};
    progLen = 0;
    spacing = 3;
    zrModel = 1'b0;
    neModel = 1'b0;
    ovModel = 1'b0;
    model[0] = '0;
    expAddr = {};
    expData = {};
  endtask

  // No forwarding in the core, so dependent words get NOPs behind them
  task automatic emitWord(input logic [15:0] word);
    prog[progLen] = word;
    progLen++;
    for (int i = 0; i < spacing; i++)
    begin
      prog[progLen] = nopWord;
      progLen++;
    end
  endtask

  task automatic expectWrite(input logic [3:0] rd, input logic [15:0] data);
    if (rd != 4'd0)
    begin
      expAddr.push_back(rd);
      expData.push_back(data);
      model[rd] = data;
    end
  endtask

  task automatic emitLlb(input logic [3:0] rd, input logic [7:0] imm8);
    emitWord(encodeImm(OpLlb, rd, imm8));
    expectWrite(rd, signExtend8(imm8));
  endtask

  task automatic emitLhb(input logic [3:0] rd, input logic [7:0] imm8);
    emitWord(encodeImm(OpLhb, rd, imm8));
    expectWrite(rd, {imm8, model[rd][7:0]});
  endtask

  task automatic loadConst(input logic [3:0] rd, input logic [15:0] value);
    emitLlb(rd, value[7:0]);
    emitLhb(rd, value[15:8]);
  endtask

  task automatic emitAlu(input opcodeT op, input logic [3:0] rd, input logic [3:0] rs,
                         input logic [3:0] rt);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] result;
    int          wide;
    a = model[rs];
    b = model[rt];
    wide = 0;
    case (op)
      OpAdd:
      begin
        result = a + b;
        wide   = int'($signed(a)) + int'($signed(b));
      end
      OpSub:
      begin
        result = a - b;
        wide   = int'($signed(a)) - int'($signed(b));
      end
      OpAnd:   result = a & b;
      OpNor:   result = ~(a | b);
      OpSll:   result = a << rt;
      OpSrl:   result = a >> rt;
      default: result = $signed(a) >>> rt;
    endcase
    zrModel = (result == 16'h0000);
    if (op == OpAdd || op == OpSub)
    begin
      neModel = result[15];
      ovModel = (wide > 32767) || (wide < -32768);
    end
    emitWord(encodeR(op, rd, rs, rt));
    expectWrite(rd, result);
  endtask

  task automatic emitStore(input logic [3:0] rd, input logic [3:0] rs, input logic [3:0] off);
    logic [7:0] addr;
    addr = 8'(model[rs] + {{12{off[3]}}, off});
    memModel[addr] = model[rd];
    emitWord(encodeR(OpSw, rd, rs, off));
  endtask

  task automatic emitLoad(input logic [3:0] rd, input logic [3:0] rs, input logic [3:0] off);
    logic [7:0] addr;
    addr = 8'(model[rs] + {{12{off[3]}}, off});
    emitWord(encodeR(OpLw, rd, rs, off));
    expectWrite(rd, memModel[addr]);
  endtask

  // Three markers after the branch retire only on the fall-through path
  task automatic branchCase(input condT cond);
    logic taken;
    logic [7:0] marker;
    taken = condHolds(cond);
    emitWord(encodeBranch(cond, 9'd3));
    for (int i = 0; i < 3; i++)
    begin
      marker = 8'(markerCount);
      markerCount++;
      emitWord(encodeImm(OpLlb, 4'(10 + i), marker));
      if (!taken)
        expectWrite(4'(10 + i), signExtend8(marker));
    end
  endtask

  // **************************************************************************
  // Running and checking
  // **************************************************************************
  task automatic applyReset();
    @(posedge clk);
    #0.5;
    rstN = 1'b0;
    repeat (16) @(posedge clk);
    #0.5;
    rstN = 1'b1;
  endtask

  task automatic runProgram(input string name, output int errs);
    logic [3:0]  gotAddr [$];
    logic [15:0] gotData [$];
    int          cycles;
    int          common;
    errs = 0;
    cycles = 0;
    applyReset();
    do
    begin
      @(negedge clk);
      cycles++;
      if (regWe)
      begin
        gotAddr.push_back(regAddr);
        gotData.push_back(regData);
      end
    end
    while (!hlt && cycles < stepLimit);
    if (!hlt)
    begin
      $display("%s: hlt never rose within %0d cycles", name, stepLimit);
      errs++;
    end
    if (gotAddr.size() != expAddr.size())
    begin
      $display("Error %s: expected %0d register writes, actual %0d", name, expAddr.size(),
               gotAddr.size());
      errs++;
    end
    common = (gotAddr.size() < expAddr.size()) ? gotAddr.size() : expAddr.size();
    for (int i = 0; i < common; i++)
    begin
      if (gotAddr[i] != expAddr[i] || gotData[i] !== expData[i])
      begin
        $display("Error %s: write %0d expected R%0d=%h, actual R%0d=%h", name, i,
                 expAddr[i], expData[i], gotAddr[i], gotData[i]);
        errs++;
      end
    end
  endtask

  task automatic reportTest(input string name, input int errs);
    if (errs == 0)
    begin
      passCount++;
      $display("%s: passed", name);
    end
    else
    begin
      failCount++;
      errorCount += errs;
      $display("%s: failed with %0d errors", name, errs);
    end
  endtask

  // **************************************************************************
  // Directed tests
  // **************************************************************************
  task automatic aluOps();
    int errs;
    startProgram();
    loadConst(4'd1, 16'h7A5C);
    loadConst(4'd2, 16'h91E3);
    emitAlu(OpAdd, 4'd3, 4'd1, 4'd2);
    emitAlu(OpSub, 4'd4, 4'd1, 4'd2);
    emitAlu(OpAnd, 4'd5, 4'd1, 4'd2);
    emitAlu(OpNor, 4'd6, 4'd1, 4'd2);
    emitAlu(OpSll, 4'd7, 4'd1, 4'd3);
    emitAlu(OpSrl, 4'd8, 4'd2, 4'd5);
    emitAlu(OpSra, 4'd9, 4'd2, 4'd5);
    // Writes to R0 never retire
    emitAlu(OpAdd, 4'd0, 4'd1, 4'd2);
    emitAlu(OpSub, 4'd10, 4'd0, 4'd1);
    runProgram("aluOps", errs);
    reportTest("aluOps", errs);
  endtask

  task automatic loadStore();
    int errs;
    startProgram();
    loadConst(4'd1, 16'h0010);
    loadConst(4'd2, 16'hBEEF);
    loadConst(4'd3, 16'h1357);
    loadConst(4'd4, 16'h8001);
    loadConst(4'd5, 16'h00FF);
    emitStore(4'd2, 4'd1, 4'h0);
    emitStore(4'd3, 4'd1, 4'h5);
    emitStore(4'd4, 4'd1, 4'hD);
    emitStore(4'd5, 4'd1, 4'h7);
    emitLoad(4'd6, 4'd1, 4'h0);
    emitLoad(4'd7, 4'd1, 4'h5);
    emitLoad(4'd8, 4'd1, 4'hD);
    emitLoad(4'd9, 4'd1, 4'h7);
    emitStore(4'd3, 4'd1, 4'h0);
    emitLoad(4'd10, 4'd1, 4'h0);
    runProgram("loadStore", errs);
    reportTest("loadStore", errs);
  endtask

  task automatic branches();
    int errs;
    startProgram();
    loadConst(4'd1, 16'd5);
    loadConst(4'd2, 16'd9);
    loadConst(4'd4, 16'h7FFF);
    spacing = 0;
    emitAlu(OpSub, 4'd3, 4'd1, 4'd2);
    for (int c = 0; c < 8; c++)
      branchCase(condT'(c));
    emitAlu(OpSub, 4'd3, 4'd1, 4'd1);
    for (int c = 0; c < 8; c++)
      branchCase(condT'(c));
    emitAlu(OpSub, 4'd3, 4'd2, 4'd1);
    for (int c = 0; c < 8; c++)
      branchCase(condT'(c));
    emitAlu(OpAdd, 4'd3, 4'd4, 4'd4);
    branchCase(CondOv);
    branchCase(CondLt);
    emitAlu(OpAnd, 4'd3, 4'd1, 4'd2);
    branchCase(CondEq);
    branchCase(CondNe);
    // A squashed SUB after a taken branch must leave the flags alone
    emitAlu(OpSub, 4'd3, 4'd1, 4'd2);
    emitWord(encodeBranch(CondAl, 9'd3));
    emitWord(encodeR(OpSub, 4'd11, 4'd1, 4'd1));
    emitWord(nopWord);
    emitWord(nopWord);
    branchCase(CondEq);
    runProgram("branches", errs);
    reportTest("branches", errs);
  endtask

  task automatic jumps();
    int errs;
    int jalAddr;
    startProgram();
    loadConst(4'd1, 16'h1234);
    spacing = 0;
    jalAddr = progLen;
    emitWord({OpJal, 12'd5});
    // Return point, then halt before the subroutine
    emitWord(encodeImm(OpLlb, 4'd7, 8'h44));
    emitWord(nopWord);
    emitWord(nopWord);
    emitWord({OpHlt, 12'h000});
    emitWord(encodeImm(OpLlb, 4'd6, 8'h66));
    // Subroutine
    emitWord(encodeImm(OpLlb, 4'd5, 8'h33));
    emitWord(nopWord);
    emitWord(nopWord);
    emitWord(nopWord);
    emitWord(encodeR(OpJr, 4'd0, 4'd15, 4'd0));
    for (int i = 0; i < 3; i++)
      emitWord(encodeImm(OpLlb, 4'd6, 8'h66));
    expectWrite(4'd15, 16'(jalAddr + 1));
    expectWrite(4'd5, 16'h0033);
    expectWrite(4'd7, 16'h0044);
    runProgram("jumps", errs);
    reportTest("jumps", errs);
  endtask

  task automatic halt();
    int errs;
    logic [15:0] pcAtHalt;
    startProgram();
    loadConst(4'd2, 16'h0BAD);
    spacing = 0;
    emitWord({OpHlt, 12'h000});
    emitWord(encodeImm(OpLlb, 4'd3, 8'h11));
    emitWord(encodeImm(OpLlb, 4'd4, 8'h22));
    emitWord(encodeImm(OpLlb, 4'd5, 8'h33));
    runProgram("halt", errs);
    pcAtHalt = pc;
    repeat (20)
    begin
      @(negedge clk);
      if (!hlt)
      begin
        $display("halt: hlt fell while the core was halted");
        errs++;
      end
      if (regWe)
      begin
        $display("halt: a register write retired after HLT");
        errs++;
      end
      if (pc !== pcAtHalt)
      begin
        $display("Error halt: pc expected %h, actual %h", pcAtHalt, pc);
        errs++;
      end
    end
    reportTest("halt", errs);
  endtask

  task automatic randomAlu();
    int errs;
    opcodeT op;
    logic [15:0] a;
    logic [15:0] b;
    startProgram();
    spacing = 0;
    for (int i = 0; i < 20; i++)
    begin
      op = opcodeT'(randomBits(2));
      a = randomBits(16);
      b = randomBits(16);
      emitLlb(4'd1, a[7:0]);
      emitLlb(4'd2, b[7:0]);
      emitWord(nopWord);
      emitWord(nopWord);
      emitLhb(4'd1, a[15:8]);
      emitLhb(4'd2, b[15:8]);
      emitWord(nopWord);
      emitWord(nopWord);
      emitWord(nopWord);
      emitAlu(op, 4'(3 + i % 8), 4'd1, 4'd2);
    end
    runProgram("randomAlu", errs);
    reportTest("randomAlu", errs);
  endtask

  initial
  begin
    clk = 1'b0;
    rstN = 1'b0;
    instr = nopWord;
    lfsr = 32'habc6_9922;
    markerCount = 1;
    passCount = 0;
    failCount = 0;
    errorCount = 0;
    aluOps();
    loadStore();
    branches();
    jumps();
    halt();
    randomAlu();
    if (UUT.portChecks.assertFailures != 0)
    begin
      $display("Bound port assertions failed %0d times", UUT.portChecks.assertFailures);
      errorCount += UUT.portChecks.assertFailures;
    end
    $display("Tests passed: %0d, tests failed: %0d, errors: %0d", passCount, failCount,
             errorCount);
    if (failCount == 0 && errorCount == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- verification/cpu_assert.sv
module cpuAssert (
  input logic       clk,
  input logic       rstN,
  input logic       hlt,
  input logic       regWe,
  input logic [3:0] regAddr
);

  timeunit 1ns;
  timeprecision 100ps;

  // Read back by the testbench at the end of the run
  int assertFailures = 0;

  // Halt is sticky until reset
  hltSticky: assert property (@(posedge clk) disable iff (!rstN) hlt |=> hlt)
  else
  begin
    $error("hlt fell without a reset");
    assertFailures++;
  end

  noWriteAfterHalt: assert property (@(posedge clk) disable iff (!rstN) hlt |-> !regWe)
  else
  begin
    $error("register write retired while halted");
    assertFailures++;
  end

  // R0 is never a write target
  noZeroWrite: assert property (@(posedge clk) disable iff (!rstN) regWe |-> regAddr != 4'd0)
  else
  begin
    $error("register write to R0 retired");
    assertFailures++;
  end

endmodule

//--- hw/cpu.sv
module cpu
  import cpuPkg::*;
(
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [dataWidth-1:0]    instr,
  output logic [dataWidth-1:0]    pc,
  output logic                    hlt,
  output logic                    regWe,
  output logic [regAddrWidth-1:0] regAddr,
  output logic [dataWidth-1:0]    regData
);

  logic [dataWidth-1:0] ifInstr;
  logic [dataWidth-1:0] ifPcNext;
  logic                 ifValid;
  logic                 hold;
  logic                 redirect;
  logic [dataWidth-1:0] redirectAddr;

  idExIf  idEx ();
  exMemIf exMem ();

  fetchStage fetch (
    .clk          (clk),
    .rstN         (rstN),
    .redirect     (redirect),
    .redirectAddr (redirectAddr),
    .hold         (hold),
    .instr        (instr),
    .pc           (pc),
    .ifInstr      (ifInstr),
    .ifPcNext     (ifPcNext),
    .ifValid      (ifValid)
  );

  // Writeback bus comes back from the memory stage
  decodeStage decode (
    .clk       (clk),
    .rstN      (rstN),
    .ifInstr   (ifInstr),
    .ifPcNext  (ifPcNext),
    .ifValid   (ifValid),
    .redirect  (redirect),
    .wbRegWe   (regWe),
    .wbRegAddr (regAddr),
    .wbRegData (regData),
    .hold      (hold),
    .idEx      (idEx.decodeMp)
  );

  executeStage execute (
    .clk      (clk),
    .rstN     (rstN),
    .redirect (redirect),
    .idEx     (idEx.executeMp),
    .exMem    (exMem.executeMp)
  );

  memoryStage memory (
    .clk          (clk),
    .rstN         (rstN),
    .exMem        (exMem.memoryMp),
    .redirect     (redirect),
    .redirectAddr (redirectAddr),
    .wbRegWe      (regWe),
    .wbRegAddr    (regAddr),
    .wbRegData    (regData),
    .hlt          (hlt)
  );

endmodule

//--- hw/memoryStage.sv
module memoryStage
  import cpuPkg::*;
(
  input  logic                    clk,
  input  logic                    rstN,
  exMemIf.memoryMp                exMem,
  output logic                    redirect,
  output logic [dataWidth-1:0]    redirectAddr,
  output logic                    wbRegWe,
  output logic [regAddrWidth-1:0] wbRegAddr,
  output logic [dataWidth-1:0]    wbRegData,
  output logic                    hlt
);

  logic [dataWidth-1:0]     dmem [dmemDepth];
  logic [dmemAddrWidth-1:0] memAddr;
  logic [dataWidth-1:0]     loadData;
  logic                     condTrue;

  // ************************************************************************
  // Branch resolution
  // ************************************************************************
  always_comb
  begin
    case (exMem.cond)
      CondNe:  condTrue = !exMem.zr;
      CondEq:  condTrue = exMem.zr;
      CondGt:  condTrue = !exMem.zr && !exMem.ne;
      CondLt:  condTrue = exMem.ne;
      CondGe:  condTrue = !exMem.ne || exMem.zr;
      CondLe:  condTrue = exMem.ne || exMem.zr;
      CondOv:  condTrue = exMem.ov;
      default: condTrue = 1'b1;
    endcase
  end

  // Flushes every younger stage for one cycle
  assign redirect     = exMem.valid && ((exMem.branch && condTrue) || exMem.jal || exMem.jr);
  assign redirectAddr = exMem.target;

  // Data memory
  assign memAddr  = exMem.aluResult[dmemAddrWidth-1:0];
  assign loadData = exMem.memRe ? dmem[memAddr] : '0;

  always_ff @(posedge clk)
  begin
    if (exMem.valid && exMem.memWe)
      dmem[memAddr] <= exMem.storeData;
  end

  // ************************************************************************
  // Writeback register and halt
  // ************************************************************************
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      wbRegWe <= 1'b0;
      hlt     <= 1'b0;
    end
    else
    begin
      wbRegWe <= exMem.valid && exMem.regWe;
      // Sticky until reset
      if (exMem.valid && exMem.halt)
        hlt <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    wbRegAddr <= exMem.dest;
    wbRegData <= exMem.memToReg ? loadData : exMem.aluResult;
  end

endmodule

//--- hw/executeStage.sv
module executeStage
  import cpuPkg::*;
(
  input  logic      clk,
  input  logic      rstN,
  input  logic      redirect,
  idExIf.executeMp  idEx,
  exMemIf.executeMp exMem
);

  logic [dataWidth-1:0] aluOut;
  logic [dataWidth-1:0] memAddr;
  logic [dataWidth-1:0] target;
  logic [3:0]           shamt;
  logic                 zrNext;
  logic                 neNext;
  logic                 ovNext;
  logic                 zrFlag;
  logic                 neFlag;
  logic                 ovFlag;
  logic                 flagWe;

  // ************************************************************************
  // ALU
  // ************************************************************************
  assign shamt = idEx.imm[3:0];

  always_comb
  begin
    ovNext = 1'b0;
    case (idEx.aluOp)
      AluAdd:
      begin
        aluOut = idEx.op1 + idEx.op2;
        ovNext = (idEx.op1[15] == idEx.op2[15]) && (aluOut[15] != idEx.op1[15]);
      end
      AluSub:
      begin
        aluOut = idEx.op1 - idEx.op2;
        ovNext = (idEx.op1[15] != idEx.op2[15]) && (aluOut[15] != idEx.op1[15]);
      end
      AluAnd:  aluOut = idEx.op1 & idEx.op2;
      AluNor:  aluOut = ~(idEx.op1 | idEx.op2);
      AluSll:  aluOut = idEx.op1 << shamt;
      AluSrl:  aluOut = idEx.op1 >> shamt;
      AluSra:  aluOut = $signed(idEx.op1) >>> shamt;
      // Keep the low byte of rd
      AluLhb:  aluOut = {idEx.imm[7:0], idEx.op2[7:0]};
      default: aluOut = idEx.op2;
    endcase
  end

  assign zrNext = (aluOut == '0);
  assign neNext = aluOut[15];

  // Word addresses, base plus signed offset
  assign memAddr = idEx.op1 + idEx.imm;
  assign target  = idEx.jr ? idEx.op1 : idEx.pcNext + idEx.imm;

  // ************************************************************************
  // Flag register
  // ************************************************************************

  // A younger instruction squashed by the redirect leaves the flags alone
  assign flagWe = idEx.valid && !redirect;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      zrFlag <= 1'b0;
      neFlag <= 1'b0;
      ovFlag <= 1'b0;
    end
    else if (flagWe)
    begin
      if (idEx.zrEn)
        zrFlag <= zrNext;
      if (idEx.neEn)
        neFlag <= neNext;
      if (idEx.ovEn)
        ovFlag <= ovNext;
    end
  end

  // EX/MEM register
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      exMem.valid <= 1'b0;
    else
      exMem.valid <= idEx.valid && !redirect;
  end

  always_ff @(posedge clk)
  begin
    exMem.aluResult <= (idEx.memRe || idEx.memWe) ? memAddr : aluOut;
    exMem.storeData <= idEx.op2;
    exMem.target    <= target;
    exMem.zr        <= zrFlag;
    exMem.ne        <= neFlag;
    exMem.ov        <= ovFlag;
    exMem.dest      <= idEx.dest;
    exMem.regWe     <= idEx.regWe;
    exMem.memRe     <= idEx.memRe;
    exMem.memWe     <= idEx.memWe;
    exMem.memToReg  <= idEx.memToReg;
    exMem.branch    <= idEx.branch;
    exMem.cond      <= idEx.cond;
    exMem.jal       <= idEx.jal;
    exMem.jr        <= idEx.jr;
    exMem.halt      <= idEx.halt;
  end

endmodule

//--- hw/decodeStage.sv
module decodeStage
  import cpuPkg::*;
(
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [dataWidth-1:0]    ifInstr,
  input  logic [dataWidth-1:0]    ifPcNext,
  input  logic                    ifValid,
  input  logic                    redirect,
  input  logic                    wbRegWe,
  input  logic [regAddrWidth-1:0] wbRegAddr,
  input  logic [dataWidth-1:0]    wbRegData,
  output logic                    hold,
  idExIf.decodeMp                 idEx
);

  logic [dataWidth-1:0]    regs [numRegs];
  opcodeT                  opcode;
  logic [regAddrWidth-1:0] rdAddr;
  logic [regAddrWidth-1:0] rsAddr;
  logic [regAddrWidth-1:0] rtAddr;
  logic [regAddrWidth-1:0] readAddrB;
  logic [regAddrWidth-1:0] dest;
  logic [dataWidth-1:0]    readA;
  logic [dataWidth-1:0]    readB;
  logic [dataWidth-1:0]    op2;
  logic [dataWidth-1:0]    imm;
  aluOpT                   aluOp;
  logic                    rawWe;
  logic                    memRe;
  logic                    memWe;
  logic                    memToReg;
  logic                    branch;
  logic                    jal;
  logic                    jr;
  logic                    halt;
  logic                    zrEn;
  logic                    neEn;
  logic                    ovEn;
  logic                    useRdPort;
  logic                    haltIssued;

  // ************************************************************************
  // Register file
  // ************************************************************************

  // R0 reads zero; a write in the same cycle is passed through
  function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] addr);
    logic [dataWidth-1:0] value;
    if (addr == '0)
      value = '0;
    else if (wbRegWe && wbRegAddr == addr)
      value = wbRegData;
    else
      value = regs[addr];
    return value;
  endfunction

  always_ff @(posedge clk)
  begin
    if (wbRegWe && wbRegAddr != '0)
      regs[wbRegAddr] <= wbRegData;
  end

  assign opcode    = opcodeT'(ifInstr[15:12]);
  assign rdAddr    = ifInstr[11:8];
  assign rsAddr    = ifInstr[7:4];
  assign rtAddr    = ifInstr[3:0];
  // SW data and the LHB low byte come from rd
  assign readAddrB = useRdPort ? rdAddr : rtAddr;
  assign readA     = readReg(rsAddr);
  assign readB     = readReg(readAddrB);

  // ************************************************************************
  // Instruction decode
  // ************************************************************************
  always_comb
  begin
    aluOp     = AluAdd;
    imm       = {{(dataWidth-8){ifInstr[7]}}, ifInstr[7:0]};
    rawWe     = 1'b0;
    memRe     = 1'b0;
    memWe     = 1'b0;
    memToReg  = 1'b0;
    branch    = 1'b0;
    jal       = 1'b0;
    jr        = 1'b0;
    halt      = 1'b0;
    zrEn      = 1'b0;
    neEn      = 1'b0;
    ovEn      = 1'b0;
    useRdPort = 1'b0;
    case (opcode)
      OpAdd, OpSub:
      begin
        aluOp = (opcode == OpAdd) ? AluAdd : AluSub;
        rawWe = 1'b1;
        zrEn  = 1'b1;
        neEn  = 1'b1;
        ovEn  = 1'b1;
      end
      OpAnd, OpNor:
      begin
        aluOp = (opcode == OpAnd) ? AluAnd : AluNor;
        rawWe = 1'b1;
        zrEn  = 1'b1;
      end
      OpSll, OpSrl, OpSra:
      begin
        aluOp = (opcode == OpSll) ? AluSll : (opcode == OpSrl) ? AluSrl : AluSra;
        imm   = {{(dataWidth-4){1'b0}}, ifInstr[3:0]};
        rawWe = 1'b1;
        zrEn  = 1'b1;
      end
      OpLw:
      begin
        imm      = {{(dataWidth-4){ifInstr[3]}}, ifInstr[3:0]};
        rawWe    = 1'b1;
        memRe    = 1'b1;
        memToReg = 1'b1;
      end
      OpSw:
      begin
        imm       = {{(dataWidth-4){ifInstr[3]}}, ifInstr[3:0]};
        memWe     = 1'b1;
        useRdPort = 1'b1;
      end
      OpLlb:
      begin
        aluOp = AluPass;
        rawWe = 1'b1;
      end
      OpLhb:
      begin
        aluOp     = AluLhb;
        rawWe     = 1'b1;
        useRdPort = 1'b1;
      end
      OpB:
      begin
        imm    = {{(dataWidth-9){ifInstr[8]}}, ifInstr[8:0]};
        branch = 1'b1;
      end
      OpJal:
      begin
        aluOp = AluPass;
        imm   = {{(dataWidth-12){ifInstr[11]}}, ifInstr[11:0]};
        rawWe = 1'b1;
        jal   = 1'b1;
      end
      OpJr:  jr   = 1'b1;
      OpHlt: halt = 1'b1;
      default: ;
    endcase
  end

  assign dest = jal ? linkReg : rdAddr;
  // AluPass forwards op2, which carries the link address or the LLB constant
  assign op2  = jal ? ifPcNext : (opcode == OpLlb) ? imm : readB;
  assign hold = ifValid && halt;

  // ************************************************************************
  // ID/EX register
  // ************************************************************************

  // HLT enters ID/EX once, the rest of the hold issues bubbles
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      idEx.valid <= 1'b0;
      haltIssued <= 1'b0;
    end
    else
    begin
      idEx.valid <= ifValid && !redirect && !haltIssued;
      if (redirect)
        haltIssued <= 1'b0;
      else if (hold)
        haltIssued <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    idEx.aluOp    <= aluOp;
    idEx.op1      <= readA;
    idEx.op2      <= op2;
    idEx.imm      <= imm;
    idEx.pcNext   <= ifPcNext;
    idEx.dest     <= dest;
    idEx.regWe    <= rawWe && (dest != '0);
    idEx.memRe    <= memRe;
    idEx.memWe    <= memWe;
    idEx.memToReg <= memToReg;
    idEx.branch   <= branch;
    idEx.cond     <= condT'(ifInstr[11:9]);
    idEx.jal      <= jal;
    idEx.jr       <= jr;
    idEx.halt     <= halt;
    idEx.zrEn     <= zrEn;
    idEx.neEn     <= neEn;
    idEx.ovEn     <= ovEn;
  end

endmodule

//--- hw/fetchStage.sv
module fetchStage
  import cpuPkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 redirect,
  input  logic [dataWidth-1:0] redirectAddr,
  input  logic                 hold,
  input  logic [dataWidth-1:0] instr,
  output logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] ifInstr,
  output logic [dataWidth-1:0] ifPcNext,
  output logic                 ifValid
);

  logic [dataWidth-1:0] pcPlusOne;

  assign pcPlusOne = pc + 1'b1;

  // Redirect wins over hold, so a squashed HLT releases fetch
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      pc      <= '0;
      ifValid <= 1'b0;
    end
    else if (redirect)
    begin
      pc      <= redirectAddr;
      ifValid <= 1'b0;
    end
    else if (!hold)
    begin
      pc      <= pcPlusOne;
      ifValid <= 1'b1;
    end
  end

  // IF/ID payload
  always_ff @(posedge clk)
  begin
    if (!redirect && !hold)
    begin
      ifInstr  <= instr;
      ifPcNext <= pcPlusOne;
    end
  end

endmodule

//--- hw/pipeIf.sv
// ID/EX pipeline register
interface idExIf
  import cpuPkg::*;
();

  logic                    valid;
  aluOpT                   aluOp;
  logic [dataWidth-1:0]    op1;
  logic [dataWidth-1:0]    op2;
  logic [dataWidth-1:0]    imm;
  logic [dataWidth-1:0]    pcNext;
  logic [regAddrWidth-1:0] dest;
  logic                    regWe;
  logic                    memRe;
  logic                    memWe;
  logic                    memToReg;
  logic                    branch;
  condT                    cond;
  logic                    jal;
  logic                    jr;
  logic                    halt;
  logic                    zrEn;
  logic                    neEn;
  logic                    ovEn;

  modport decodeMp (
    output valid, aluOp, op1, op2, imm, pcNext, dest, regWe, memRe, memWe, memToReg,
           branch, cond, jal, jr, halt, zrEn, neEn, ovEn
  );

  modport executeMp (
    input valid, aluOp, op1, op2, imm, pcNext, dest, regWe, memRe, memWe, memToReg,
          branch, cond, jal, jr, halt, zrEn, neEn, ovEn
  );

endinterface

// EX/MEM pipeline register
interface exMemIf
  import cpuPkg::*;
();

  logic                    valid;
  logic [dataWidth-1:0]    aluResult;
  logic [dataWidth-1:0]    storeData;
  logic [dataWidth-1:0]    target;
  // Flags as seen by this instruction
  logic                    zr;
  logic                    ne;
  logic                    ov;
  logic [regAddrWidth-1:0] dest;
  logic                    regWe;
  logic                    memRe;
  logic                    memWe;
  logic                    memToReg;
  logic                    branch;
  condT                    cond;
  logic                    jal;
  logic                    jr;
  logic                    halt;

  modport executeMp (
    output valid, aluResult, storeData, target, zr, ne, ov, dest, regWe, memRe, memWe,
           memToReg, branch, cond, jal, jr, halt
  );

  modport memoryMp (
    input valid, aluResult, storeData, target, zr, ne, ov, dest, regWe, memRe, memWe,
          memToReg, branch, cond, jal, jr, halt
  );

endinterface

//--- hw/cpuPkg.sv
package cpuPkg;

  // ************************************************************************
  // Widths and sizes
  // ************************************************************************
  localparam int dataWidth = 16;
  localparam int regAddrWidth = 4;
  localparam int numRegs = 2 ** regAddrWidth;
  localparam int dmemDepth = 256;
  localparam int dmemAddrWidth = $clog2(dmemDepth);

  // JAL writes its return address here
  localparam logic [regAddrWidth-1:0] linkReg = 4'd15;

  // ************************************************************************
  // Encodings
  // ************************************************************************

  // Opcode in instr[15:12]
  typedef enum logic [3:0] {
    OpAdd = 4'h0,
    OpSub = 4'h1,
    OpAnd = 4'h2,
    OpNor = 4'h3,
    OpSll = 4'h4,
    OpSrl = 4'h5,
    OpSra = 4'h6,
    OpLw  = 4'h7,
    OpSw  = 4'h8,
    OpLlb = 4'h9,
    OpLhb = 4'hA,
    OpB   = 4'hB,
    OpJal = 4'hC,
    OpJr  = 4'hD,
    OpNop = 4'hE,
    OpHlt = 4'hF
  } opcodeT;

  // Branch condition in instr[11:9]
  typedef enum logic [2:0] {
    CondNe = 3'd0,
    CondEq = 3'd1,
    CondGt = 3'd2,
    CondLt = 3'd3,
    CondGe = 3'd4,
    CondLe = 3'd5,
    CondOv = 3'd6,
    CondAl = 3'd7
  } condT;

  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluNor,
    AluSll,
    AluSrl,
    AluSra,
    AluLhb,
    AluPass
  } aluOpT;

endpackage
